/* Makefile */
# Verilator build and run of the flow scheduler testbench
TOOL     := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP      := flow_sched_tb
FILELIST := compile.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, search the log for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/flow_sched_model.svh */
// Reference model of flow virtual times and winner choice, plus typed compare tasks
`ifndef FLOW_SCHED_MODEL_SVH
`define FLOW_SCHED_MODEL_SVH

// Model state, one entry per flow
bvt_pkg::vtime_t  model_vtime  [NumFlows];
bvt_pkg::weight_t model_weight [NumFlows];

// Running count of failed checks over the whole run
int unsigned check_errs;

// State right after reset
task automatic model_reset();
  for (int i = 0; i < NumFlows; i++) begin
    model_vtime[i]  = '0;
    model_weight[i] = flow_cfg_pkg::ResetWeight;
  end
endtask

// Smallest virtual time among the requesting flows
task automatic model_pick(input flow_vec_t req, output logic valid, output idx_t idx);
  valid = 1'b0;
  idx   = '0;
  for (int i = 0; i < NumFlows; i++) begin
    // Strictly smaller, so the lowest index keeps a tie
    if (req[i] && (!valid || model_vtime[i] < model_vtime[idx])) begin
      valid = 1'b1;
      idx   = idx_t'(i);
    end
  end
endtask

// Counter and weight update at the clock edge that ends a row
task automatic model_advance(input stim_t row);
  logic win_valid;
  idx_t win_idx;
  model_pick(row.req, win_valid, win_idx);
  for (int i = 0; i < NumFlows; i++) begin
    // Advance by the old weight, truncation gives the wrap
    model_vtime[i] = bvt_pkg::vtime_t'(model_vtime[i] + bvt_pkg::vtime_t'(model_weight[i]));
  end
  // Served flow restarts at zero
  if (win_valid && row.gnt) begin
    model_vtime[win_idx] = '0;
  end
  // New weight counts from the next edge on
  if (row.we && int'(row.widx) < NumFlows) begin
    model_weight[row.widx] = row.wval;
  end
endtask

task automatic check_idx(input string test_name, input idx_t exp, input idx_t act);
  if (exp !== act) begin
    $display("Fail %s idx_o: expected %0d, actual %0d", test_name, exp, act);
    check_errs++;
  end
endtask

task automatic check_payload(input string test_name, input flow_cfg_pkg::payload_t exp,
                             input flow_cfg_pkg::payload_t act);
  if (exp !== act) begin
    $display("Fail %s data_o: expected %h, actual %h", test_name, exp, act);
    check_errs++;
  end
endtask

task automatic check_gnt(input string test_name, input flow_vec_t exp, input flow_vec_t act);
  if (exp !== act) begin
    $display("Fail %s gnt_o: expected %b, actual %b", test_name, exp, act);
    check_errs++;
  end
endtask

task automatic check_req(input string test_name, input logic exp, input logic act);
  if (exp !== act) begin
    $display("Fail %s req_o: expected %b, actual %b", test_name, exp, act);
    check_errs++;
  end
endtask

`endif

/* bench/flow_sched_tb.sv */
// Clock, reset, stimulus table, model checks and watchdog of the flow scheduler testbench
`timescale 1ns/1ps

module flow_sched_tb;

  localparam int NumFlows    = 4;
  localparam int IdxWidth    = $clog2(NumFlows);
  localparam int ClkPeriod   = 40;
  localparam int DriveDelay  = 2;
  localparam int ResetCycles = 2;

  typedef logic [NumFlows-1:0] flow_vec_t;
  typedef logic [IdxWidth-1:0] idx_t;

  // One table row holds the inputs of one clock cycle
  typedef struct packed {
    flow_vec_t                             req;
    flow_cfg_pkg::payload_t [NumFlows-1:0] data;
    logic                                  gnt;
    logic                                  we;
    idx_t                                  widx;
    bvt_pkg::weight_t                      wval;
  } stim_t;

  `include "flow_sched_model.svh"

  logic                                  clk_i;
  logic                                  rst_ni;
  flow_vec_t                             req_i;
  flow_cfg_pkg::payload_t [NumFlows-1:0] data_i;
  flow_vec_t                             gnt_o;
  logic                                  req_o;
  logic                                  gnt_i;
  flow_cfg_pkg::payload_t                data_o;
  idx_t                                  idx_o;
  logic                                  cfg_we_i;
  idx_t                                  cfg_idx_i;
  bvt_pkg::weight_t                      cfg_weight_i;

  // Stimulus table with a hand-derived winner where one is known and -1 otherwise
  stim_t row_q  [$];
  string name_q [$];
  int    exp_q  [$];
  logic  table_ready = 1'b0;

  // Winners seen at transfers during the weighted run
  int win_cnt [NumFlows];

  flow_sched_top #(
    .NumFlows (NumFlows)
  ) dut_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .data_i       (data_i),
    .gnt_o        (gnt_o),
    .req_o        (req_o),
    .gnt_i        (gnt_i),
    .data_o       (data_o),
    .idx_o        (idx_o),
    .cfg_we_i     (cfg_we_i),
    .cfg_idx_i    (cfg_idx_i),
    .cfg_weight_i (cfg_weight_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Append one row with random payloads
  task automatic push_row(input string name, input flow_vec_t req, input logic gnt,
                          input logic we, input idx_t widx, input bvt_pkg::weight_t wval,
                          input int exp);
    stim_t row;
    row.req = req;
    for (int i = 0; i < NumFlows; i++) begin
      row.data[i] = flow_cfg_pkg::payload_t'($urandom);
    end
    row.gnt  = gnt;
    row.we   = we;
    row.widx = widx;
    row.wval = wval;
    row_q.push_back(row);
    name_q.push_back(name);
    exp_q.push_back(exp);
  endtask

  task automatic add_row(input string name, input flow_vec_t req, input logic gnt,
                         input int exp);
    push_row(name, req, gnt, 1'b0, '0, '0, exp);
  endtask

  task automatic add_write(input string name, input flow_vec_t req, input logic gnt,
                           input idx_t widx, input bvt_pkg::weight_t wval);
    push_row(name, req, gnt, 1'b1, widx, wval, -1);
  endtask

  task automatic build_table();
    // Idle after reset with the grant high and nothing to serve
    add_row("reset_idle", 4'b0000, 1'b1, 0);
    add_row("reset_idle", 4'b0000, 1'b0, 0);
    // All times equal at 2 so the lowest index wins
    add_row("tie_all_req", 4'b1111, 1'b0, 0);
    // Served flow drops out, so each flow gets one turn
    add_row("equal_rotation", 4'b1111, 1'b1, 0);
    add_row("equal_rotation", 4'b1110, 1'b1, 1);
    add_row("equal_rotation", 4'b1100, 1'b1, 2);
    add_row("equal_rotation", 4'b1000, 1'b1, 3);
    // Weights 1, 2, 4 and 8 then a long run with sparse grants
    add_write("weighted_run", 4'b0000, 1'b0, 2'd1, 4'd2);
    add_write("weighted_run", 4'b0000, 1'b0, 2'd2, 4'd4);
    add_write("weighted_run", 4'b0000, 1'b0, 2'd3, 4'd8);
    for (int i = 0; i < 40; i++) begin
      add_row("weighted_run", (i % 8 == 7) ? 4'b1110 : 4'b1111, (i % 4 == 3), -1);
    end
    // No transfers so every counter keeps running
    for (int i = 0; i < 6; i++) begin
      add_row("gnt_low_hold", 4'b1111, 1'b0, -1);
    end
    add_row("late_grant", 4'b1111, 1'b1, -1);
    add_row("partial_req", 4'b0101, 1'b1, -1);
    add_row("partial_req", 4'b1010, 1'b1, -1);
    add_row("partial_req", 4'b0010, 1'b0, -1);
    add_row("partial_req", 4'b1001, 1'b1, -1);
    add_row("partial_req", 4'b0110, 1'b1, -1);
    add_row("partial_req", 4'b0000, 1'b1, -1);
    // Flow 2 served to zero and frozen there
    add_write("zero_weight", 4'b0100, 1'b1, 2'd2, 4'd0);
    for (int i = 0; i < 4; i++) begin
      add_row("zero_weight", 4'b1111, (i % 2 == 1), 2);
    end
    // Flow 3 cleared and then running at 15 per cycle past 4095
    add_write("wrap_around", 4'b1000, 1'b1, 2'd3, 4'd15);
    for (int j = 0; j < 275; j++) begin
      add_row("wrap_around", 4'b1001, 1'b0, (j == 273) ? 0 : ((j == 274) ? 3 : -1));
    end
  endtask

  task automatic drive_row(input stim_t row);
    req_i        = row.req;
    data_i       = row.data;
    gnt_i        = row.gnt;
    cfg_we_i     = row.we;
    cfg_idx_i    = row.widx;
    cfg_weight_i = row.wval;
  endtask

  // Watchdog sized from the table length
  initial begin
    wait (table_ready);
    #((row_q.size() + ResetCycles + 10) * ClkPeriod);
    $display("Timeout: the scheduler run did not reach its end in time");
    $display(">>> FAIL");
    $finish;
  end

  stim_t       row;
  logic        exp_valid;
  idx_t        exp_idx;
  flow_vec_t   exp_gnt;
  int unsigned errs_at_start;
  int          test_cycles;
  int          tests_run;
  int          tests_failed;

  initial begin
    void'($urandom(90));
    check_errs    = 0;
    tests_run     = 0;
    tests_failed  = 0;
    errs_at_start = 0;
    test_cycles   = 0;
    for (int i = 0; i < NumFlows; i++) begin
      win_cnt[i] = 0;
    end
    rst_ni       = 1'b0;
    req_i        = '0;
    data_i       = '0;
    gnt_i        = 1'b0;
    cfg_we_i     = 1'b0;
    cfg_idx_i    = '0;
    cfg_weight_i = '0;
    build_table();
    table_ready = 1'b1;
    model_reset();

    repeat (ResetCycles) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;

    for (int r = 0; r < row_q.size(); r++) begin
      row = row_q[r];
      drive_row(row);
      test_cycles++;
      // Outputs are settled half a cycle later
      @(negedge clk_i);
      model_pick(row.req, exp_valid, exp_idx);
      exp_gnt = '0;
      if (exp_valid && row.gnt) begin
        exp_gnt[exp_idx] = 1'b1;
      end
      check_req(name_q[r], exp_valid, req_o);
      check_idx(name_q[r], exp_idx, idx_o);
      check_gnt(name_q[r], exp_gnt, gnt_o);
      // Payload only has a meaning while some flow requests
      if (exp_valid) begin
        check_payload(name_q[r], row.data[exp_idx], data_o);
      end
      if (exp_q[r] >= 0) begin
        check_idx(name_q[r], idx_t'(exp_q[r]), idx_o);
      end
      if (req_o === 1'b1 && !row.req[idx_o]) begin
        $display("Error in %s: flow %0d won without requesting", name_q[r], idx_o);
        check_errs++;
      end
      if (name_q[r] == "weighted_run" && req_o === 1'b1 && row.gnt) begin
        win_cnt[idx_o]++;
      end
      model_advance(row);

      // Test ends where the next row belongs to another test
      if (r == row_q.size() - 1 || name_q[r + 1] != name_q[r]) begin
        if (name_q[r] == "weighted_run" && win_cnt[0] <= win_cnt[3]) begin
          $display("Error in weighted_run: the lightest flow did not win more often");
          check_errs++;
        end
        tests_run++;
        if (check_errs == errs_at_start) begin
          $display("Test %s: ok, %0d cycles", name_q[r], test_cycles);
        end else begin
          tests_failed++;
          $display("Test %s: %0d errors in %0d cycles", name_q[r],
                   check_errs - errs_at_start, test_cycles);
        end
        errs_at_start = check_errs;
        test_cycles   = 0;
      end
      @(posedge clk_i);
      #DriveDelay;
    end

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_run - tests_failed, tests_failed, check_errs);
    if (tests_failed == 0 && check_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+bench
rtl/bvt_pkg.sv
rtl/flow_cfg_pkg.sv
rtl/min_max_tree.sv
rtl/weight_regfile.sv
rtl/bvt_arb_tree.sv
rtl/flow_sched_top.sv
bench/flow_sched_tb.sv

/* rtl/bvt_arb_tree.sv */
// Borrowed-virtual-time arbiter: per-flow time counters, minimum search, grant and payload steering
`timescale 1ns/1ps

module bvt_arb_tree #(
  parameter int unsigned NumIn = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Per-flow time increment
  input  bvt_pkg::weight_t [NumIn-1:0]         weight_i,
  // Request levels of the input flows
  input  logic [NumIn-1:0]                     req_i,
  // One-hot grant back to the winning flow
  output logic [NumIn-1:0]                     gnt_o,
  // Payload of each input flow
  input  flow_cfg_pkg::payload_t [NumIn-1:0]   data_i,
  // At least one flow requests
  output logic                                 req_o,
  // Downstream grant level
  input  logic                                 gnt_i,
  // Payload of the winning flow
  output flow_cfg_pkg::payload_t               data_o,
  // Index of the winning flow
  output logic [((NumIn > 1) ? $clog2(NumIn) : 1)-1:0] idx_o
);

  localparam int unsigned IdxWidth = (NumIn > 1) ? $clog2(NumIn) : 1;

  // Virtual time of every flow
  bvt_pkg::vtime_t [NumIn-1:0] vtime_d, vtime_q;

  // Transfer completes when the output request meets the downstream grant
  logic xfer;
  logic [IdxWidth-1:0] win_idx;

  // Smallest virtual time among the requesting flows
  // The minimum value itself is not needed here
  min_max_tree #(
    .NumIn     (NumIn),
    .DataWidth (bvt_pkg::TimeWidth)
  ) i_min_tree (
    .data_i   (vtime_q),
    .valid_i  (req_i),
    .is_max_i (1'b0),
    .data_o   (),
    .valid_o  (req_o),
    .idx_o    (win_idx)
  );

  assign idx_o = win_idx;
  assign xfer  = req_o & gnt_i;

  // Next counter values
  always_comb begin
    // Every flow advances by its weight, requesting or not
    for (int unsigned i = 0; i < NumIn; i++) begin
      vtime_d[i] = vtime_q[i] + bvt_pkg::vtime_t'(weight_i[i]);
    end
    // Served flow restarts from zero instead of advancing
    if (xfer) begin
      vtime_d[win_idx] = '0;
    end
  end

  // Steer the downstream grant to the winner only
  always_comb begin
    gnt_o          = '0;
    gnt_o[win_idx] = xfer;
  end

  // Winner's payload goes downstream
  assign data_o = data_i[win_idx];

  // Counter state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vtime_q <= '0;
    end else begin
      vtime_q <= vtime_d;
    end
  end

endmodule

/* rtl/bvt_pkg.sv */
// Virtual-time and weight widths and their vector types for the BVT scheduler
package bvt_pkg;

  // Width of one virtual-time counter
  // Small enough that wrap-around shows up in short runs
  localparam int unsigned TimeWidth = 12;

  // Width of one flow weight
  localparam int unsigned WeightWidth = 4;

  // Virtual time of a flow
  // Counters wrap silently, no saturation
  typedef logic [TimeWidth-1:0] vtime_t;

  // Per-cycle time increment of a flow
  // Larger weight means time runs faster, so the flow is chosen less often
  // Zero freezes the flow's time
  typedef logic [WeightWidth-1:0] weight_t;

endpackage

/* rtl/flow_cfg_pkg.sv */
// Flow payload type and the weight each flow holds after reset
package flow_cfg_pkg;

  // Width of the payload carried with each request
  localparam int unsigned PayloadWidth = 16;

  // Payload word travelling alongside a flow's request
  typedef logic [PayloadWidth-1:0] payload_t;

  // Weight loaded into every flow on reset
  // Equal weights give plain round-robin-like rotation
  localparam bvt_pkg::weight_t ResetWeight = bvt_pkg::weight_t'(1);

endpackage

/* rtl/flow_sched_top.sv */
// Weighted flow scheduler top level joining the weight register bank and the BVT arbiter
`timescale 1ns/1ps

module flow_sched_top #(
  parameter int unsigned NumFlows = 4
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Flow side
  input  logic [NumFlows-1:0]                           req_i,
  input  flow_cfg_pkg::payload_t [NumFlows-1:0]         data_i,
  output logic [NumFlows-1:0]                           gnt_o,
  // Downstream side
  output logic                                          req_o,
  input  logic                                          gnt_i,
  output flow_cfg_pkg::payload_t                        data_o,
  output logic [((NumFlows > 1) ? $clog2(NumFlows) : 1)-1:0] idx_o,
  // Weight configuration
  input  logic                                          cfg_we_i,
  input  logic [((NumFlows > 1) ? $clog2(NumFlows) : 1)-1:0] cfg_idx_i,
  input  bvt_pkg::weight_t                              cfg_weight_i
);

  // Weights from the register bank into the arbiter
  bvt_pkg::weight_t [NumFlows-1:0] weight;

  weight_regfile #(
    .NumFlows (NumFlows)
  ) i_weight_regfile (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_we_i     (cfg_we_i),
    .cfg_idx_i    (cfg_idx_i),
    .cfg_weight_i (cfg_weight_i),
    .weight_o     (weight)
  );

  // All outputs are combinational from the current requests and counters
  bvt_arb_tree #(
    .NumIn (NumFlows)
  ) i_bvt_arb_tree (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .weight_i (weight),
    .req_i    (req_i),
    .gnt_o    (gnt_o),
    .data_i   (data_i),
    .req_o    (req_o),
    .gnt_i    (gnt_i),
    .data_o   (data_o),
    .idx_o    (idx_o)
  );

endmodule

/* rtl/min_max_tree.sv */
// Combinational compare tree returning the smallest or largest valid value and its index
`timescale 1ns/1ps

module min_max_tree #(
  parameter int unsigned NumIn     = 4,
  parameter int unsigned DataWidth = 8
) (
  // Candidate values, one per input
  input  logic [NumIn-1:0][DataWidth-1:0] data_i,
  // Only valid inputs take part in the search
  input  logic [NumIn-1:0]                valid_i,
  // High selects the maximum, low the minimum
  input  logic                            is_max_i,
  output logic [DataWidth-1:0]            data_o,
  output logic                            valid_o,
  output logic [((NumIn > 1) ? $clog2(NumIn) : 1)-1:0] idx_o
);

  // Index width derived from the input count
  localparam int unsigned IdxWidth = (NumIn > 1) ? $clog2(NumIn) : 1;
  // Leaves padded up to a power of two so the tree stays balanced
  localparam int unsigned NumLeaves = 2 ** IdxWidth;
  // Heap layout with the children of node n at 2n+1 and 2n+2 and the leaves at the bottom
  localparam int unsigned NumNodes = 2 * NumLeaves - 1;

  typedef logic [IdxWidth-1:0] idx_t;

  always_comb begin
    logic [DataWidth-1:0] node_data  [NumNodes];
    logic                 node_valid [NumNodes];
    idx_t                 node_idx   [NumNodes];
    logic                 right_better;
    logic                 pick_right;

    // Leaf level
    for (int unsigned i = 0; i < NumLeaves; i++) begin
      if (i < NumIn) begin
        node_data[NumLeaves-1+i]  = data_i[i];
        node_valid[NumLeaves-1+i] = valid_i[i];
      end else begin
        // Padding leaves never win
        node_data[NumLeaves-1+i]  = '0;
        node_valid[NumLeaves-1+i] = 1'b0;
      end
      node_idx[NumLeaves-1+i] = idx_t'(i);
    end

    // Compare nodes from the bottom up, each picks one of its two children
    for (int n = int'(NumLeaves) - 2; n >= 0; n--) begin
      // Strict compare so that equal values keep the left, lower-index child
      right_better = is_max_i ? (node_data[2*n+2] > node_data[2*n+1])
                              : (node_data[2*n+2] < node_data[2*n+1]);

      // An invalid child always loses
      // Both invalid falls back to the left child, which drives index zero at the root
      pick_right = node_valid[2*n+2] & (~node_valid[2*n+1] | right_better);

      node_data[n]  = pick_right ? node_data[2*n+2] : node_data[2*n+1];
      node_idx[n]   = pick_right ? node_idx[2*n+2]  : node_idx[2*n+1];
      node_valid[n] = node_valid[2*n+1] | node_valid[2*n+2];
    end

    // Root of the tree
    data_o  = node_data[0];
    valid_o = node_valid[0];
    idx_o   = node_idx[0];
  end

endmodule

/* rtl/weight_regfile.sv */
// Per-flow weight registers loaded through a configuration write strobe
`timescale 1ns/1ps

module weight_regfile #(
  parameter int unsigned NumFlows = 4
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Write strobe, one entry per cycle
  input  logic                                          cfg_we_i,
  // Flow to be written
  input  logic [((NumFlows > 1) ? $clog2(NumFlows) : 1)-1:0] cfg_idx_i,
  // New weight for that flow
  input  bvt_pkg::weight_t                              cfg_weight_i,
  // Current weight of every flow
  output bvt_pkg::weight_t [NumFlows-1:0]               weight_o
);

  localparam int unsigned IdxWidth = (NumFlows > 1) ? $clog2(NumFlows) : 1;

  bvt_pkg::weight_t [NumFlows-1:0] weight_q;

  // Only the addressed entry updates
  // An index with no matching flow leaves all entries untouched
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < NumFlows; i++) begin
        weight_q[i] <= flow_cfg_pkg::ResetWeight;
      end
    end else if (cfg_we_i) begin
      for (int unsigned i = 0; i < NumFlows; i++) begin
        if (cfg_idx_i == IdxWidth'(i)) begin
          weight_q[i] <= cfg_weight_i;
        end
      end
    end
  end

  // Zero weight is legal, it holds that flow's time still
  assign weight_o = weight_q;

endmodule
